/* Bender.yml */
package:
  name: instruction_cache

sources:
  - files:
      - hw/icachePkg.sv
      - hw/icacheBank.sv
      - hw/fetchStage.sv
      - hw/fetchWindow.sv
      - hw/ringMissUnit.sv
      - hw/instructionCache.sv
  - target: test
    files:
      - verification/instructionCache_sva.sv
      - verification/instructionCacheTb.sv

/* hw/fetchStage.sv */
//////////////////////////////
// Fetch address stage, one cycle ahead of the bank outputs
// Replays its latched request while hold or a load is pending
// Flush on a new flush opm on pcOpm, or on reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input wire clock,
	input wire reset,
	input wire icachePkg::pcAddr pcIn,
	input wire pcHold,
	input wire icachePkg::cacheOpm pcOpm,
	input wire icachePkg::lineRead evenLine,
	input wire icachePkg::lineRead oddLine,
	input wire missLoadPending,
	output icachePkg::fetchRequest request,
	output icachePkg::lineIndex evenIndex,
	output icachePkg::lineIndex oddIndex,
	output icachePkg::pcAddr latchedPc,
	output logic flush,
	output logic missEven,
	output logic missOdd
);

	icachePkg::lineAddr pcLine;
	icachePkg::lineAddr nextLine;
	icachePkg::fetchRequest freshRequest;
	icachePkg::fetchRequest nextRequest;
	icachePkg::pcAddr nextPc;
	icachePkg::cacheOpm opmDelay1;
	icachePkg::cacheOpm opmDelay2;
	logic replay;
	logic newFlush;
	logic fetchLive;		// Low until the first fetch after reset
	logic evenHit;
	logic oddHit;

	assign pcLine = pcIn[47:4];
	assign nextLine = pcLine + 44'd1;
	assign replay = pcHold || missLoadPending;

	// PC bit 4 says which bank holds the line at the PC
	always_comb
	begin
		if (pcIn[4])
		begin
			freshRequest.evenLine = nextLine;
			freshRequest.oddLine = pcLine;
		end
		else
		begin
			freshRequest.evenLine = pcLine;
			freshRequest.oddLine = nextLine;
		end
		freshRequest.evenIndex = freshRequest.evenLine[6:1];
		freshRequest.oddIndex = freshRequest.oddLine[6:1];
	end

	assign nextRequest = replay ? request : freshRequest;
	assign nextPc = replay ? latchedPc : pcIn;
	assign evenIndex = nextRequest.evenIndex;		// Bank read address
	assign oddIndex = nextRequest.oddIndex;

	always_ff @(posedge clock)
	begin
		latchedPc <= nextPc;
		request <= nextRequest;
	end

	assign newFlush = (opmDelay1 == icachePkg::opmFlushIcache) &&
		(opmDelay2 != icachePkg::opmFlushIcache);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetchLive <= 1'b0;
			opmDelay1 <= '0;
			opmDelay2 <= '0;
			flush <= 1'b1;		// Reset flushes both banks
		end
		else
		begin
			fetchLive <= 1'b1;
			opmDelay1 <= pcOpm;
			opmDelay2 <= opmDelay1;
			flush <= newFlush;
		end
	end

	assign evenHit = evenLine.valid && (evenLine.tag == request.evenLine);
	assign oddHit = oddLine.valid && (oddLine.tag == request.oddLine);
	assign missEven = fetchLive && !evenHit;
	assign missOdd = fetchLive && !oddHit;

endmodule

`default_nettype wire

/* hw/fetchWindow.sv */
//////////////////////////////
// 96-bit window at the PC and PC step decode
// Jumbo prefixes are decoded as plain wide words
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetchWindow (
	input wire icachePkg::lineRead evenLine,
	input wire icachePkg::lineRead oddLine,
	input wire icachePkg::pcAddr latchedPc,
	input wire wexEnable,
	output icachePkg::fetchWord pcValue,
	output icachePkg::pcStep pcStep
);

	logic [255:0] pairData;		// Two lines in PC order
	logic [159:0] groupData;	// From the PC's 64-bit group
	logic [5:0] shortOp;
	logic [5:0] wideOp;
	logic [1:0] wordIx;
	logic [2:0] nextIx;
	logic firstShort;
	logic firstWide;
	logic secondWide;

	// Bits 12:9 of a 32-bit op that marks it as wide
	function automatic logic isWideCode(input logic [3:0] code);
		logic wide;
		casez (code)
			4'b111?: wide = 1'b1;
			4'b101?: wide = 1'b1;
			4'b0111: wide = 1'b1;
			4'b0101: wide = 1'b1;
			default: wide = 1'b0;
		endcase
		return wide;
	endfunction

	always_comb
	begin
		if (latchedPc[4])
			pairData = {evenLine.data, oddLine.data};
		else
			pairData = {oddLine.data, evenLine.data};
		groupData = pairData[{latchedPc[3], 6'd0} +: 160];
		pcValue = groupData[{latchedPc[2:1], 4'd0} +: 96];
	end

	// Six candidate words, enough for any start plus 4 bytes
	always_comb
	begin
		for (int i = 0; i < 6; i++)
		begin
			shortOp[i] = groupData[16*i+13 +: 3] != 3'b111;
			wideOp[i] = !shortOp[i] && isWideCode(groupData[16*i+9 +: 4]);
		end
	end

	assign wordIx = latchedPc[2:1];
	assign nextIx = {1'b0, wordIx} + 3'd2;		// Op 4 bytes on
	assign firstShort = shortOp[wordIx];
	assign firstWide = wideOp[wordIx];
	assign secondWide = wideOp[nextIx];

	always_comb
	begin
		if (wexEnable && firstWide)
			pcStep = secondWide ? 4'd12 : 4'd8;
		else
			pcStep = firstShort ? 4'd2 : 4'd4;
	end

endmodule

`default_nettype wire

/* hw/icacheBank.sv */
//////////////////////////////
// One direct-mapped bank, read registered on the index
// A fill to the index being read is forwarded to the read
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icacheBank (
	input wire clock,
	input wire reset,
	input wire flush,
	input wire icachePkg::lineIndex readIndex,
	input wire icachePkg::bankFill fill,
	output icachePkg::lineRead line
);

	icachePkg::lineAddr tagMem [icachePkg::entryCount];
	icachePkg::lineData dataMem [icachePkg::entryCount];
	logic [icachePkg::entryCount-1:0] validBits;
	logic bypass;

	assign bypass = fill.valid && (fill.index == readIndex);	// Fill lands on the read

	always_ff @(posedge clock)
	begin
		if (fill.valid)
		begin
			tagMem[fill.index] <= fill.tag;
			dataMem[fill.index] <= fill.data;
		end
	end

	// Fills in flight still set their bit over a flush
	always_ff @(posedge clock)
	begin
		if (reset || flush)
			validBits <= '0;
		if (fill.valid && !reset)
			validBits[fill.index] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		line.tag <= bypass ? fill.tag : tagMem[readIndex];
		line.data <= bypass ? fill.data : dataMem[readIndex];
		if (reset)
			line.valid <= 1'b0;
		else
			line.valid <= bypass || validBits[readIndex];
	end

endmodule

`default_nettype wire

/* hw/icachePkg.sv */
//////////////////////////////
// Shared types for the two-bank L1 instruction cache
// Fixed at 48-bit PC, 16-byte lines and 64 entries per bank
// Ring slot layout follows the ring bus opm/seq/addr/data order
//////////////////////////////

`default_nettype none

package icachePkg;

	typedef logic [47:0] pcAddr;		// PC or byte address
	typedef logic [43:0] lineAddr;		// PC without the byte offset
	typedef logic [5:0] lineIndex;		// Line address bits 6:1
	typedef logic [127:0] lineData;
	typedef logic [95:0] fetchWord;		// Window handed to fetch
	typedef logic [3:0] pcStep;			// Step in bytes
	typedef logic [1:0] pcOkCode;
	typedef logic [5:0] cacheOpm;
	typedef logic [7:0] nodeId;
	typedef logic [3:0] seqTag;			// Request sequence rover

	typedef logic [15:0] ringOpm;
	typedef logic [15:0] ringSeq;

	localparam int entryCount = 64;		// Entries per bank

	localparam pcOkCode okReady = 2'b01;
	localparam pcOkCode okHold = 2'b10;

	localparam logic [7:0] opmIdle = 8'h00;
	localparam logic [7:0] opmLoadLine = 8'h97;	// Line load, 128 bits
	localparam cacheOpm opmFlushIcache = 6'h2E;

	typedef struct packed {
		ringOpm opm;
		ringSeq seq;		// Node, bank bits, rover
		pcAddr addr;
		lineData data;
	} ringSlot;

	typedef struct packed {
		logic valid;		// Write strobe
		lineIndex index;
		lineAddr tag;
		lineData data;
	} bankFill;

	typedef struct packed {
		logic valid;
		lineAddr tag;
		lineData data;
	} lineRead;

	typedef struct packed {
		lineAddr evenLine;
		lineAddr oddLine;
		lineIndex evenIndex;
		lineIndex oddIndex;
	} fetchRequest;

endpackage

`default_nettype wire

/* hw/instructionCache.sv */
//////////////////////////////
// L1 instruction cache top, even and odd banks
// One cycle from PC sample to window; misses hold via pcOk
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instructionCache (
	input wire clock,
	input wire reset,
	input wire icachePkg::pcAddr pcIn,
	input wire pcHold,
	input wire wexEnable,
	input wire icachePkg::cacheOpm pcOpm,
	input wire icachePkg::ringSlot ringIn,
	input wire icachePkg::nodeId unitNodeId,
	output icachePkg::fetchWord pcValue,
	output icachePkg::pcOkCode pcOk,
	output icachePkg::pcStep pcStep,
	output logic memWait,
	output icachePkg::ringSlot ringOut
);

	icachePkg::fetchRequest request;
	icachePkg::lineIndex evenIndex;
	icachePkg::lineIndex oddIndex;
	icachePkg::pcAddr latchedPc;
	icachePkg::lineRead evenLine;
	icachePkg::lineRead oddLine;
	icachePkg::bankFill evenFill;
	icachePkg::bankFill oddFill;
	logic flush;
	logic missEven;
	logic missOdd;
	logic loadPending;

	fetchStage i_fetchStage (
		.clock(clock),
		.reset(reset),
		.pcIn(pcIn),
		.pcHold(pcHold),
		.pcOpm(pcOpm),
		.evenLine(evenLine),
		.oddLine(oddLine),
		.missLoadPending(loadPending),
		.request(request),
		.evenIndex(evenIndex),
		.oddIndex(oddIndex),
		.latchedPc(latchedPc),
		.flush(flush),
		.missEven(missEven),
		.missOdd(missOdd)
	);

	icacheBank i_evenBank (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.readIndex(evenIndex),
		.fill(evenFill),
		.line(evenLine)
	);

	icacheBank i_oddBank (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.readIndex(oddIndex),
		.fill(oddFill),
		.line(oddLine)
	);

	fetchWindow i_fetchWindow (
		.evenLine(evenLine),
		.oddLine(oddLine),
		.latchedPc(latchedPc),
		.wexEnable(wexEnable),
		.pcValue(pcValue),
		.pcStep(pcStep)
	);

	ringMissUnit i_ringMissUnit (
		.clock(clock),
		.reset(reset),
		.unitNodeId(unitNodeId),
		.ringIn(ringIn),
		.request(request),
		.missEven(missEven),
		.missOdd(missOdd),
		.ringOut(ringOut),
		.evenFill(evenFill),
		.oddFill(oddFill),
		.memWait(memWait),
		.loadPending(loadPending)
	);

	// Hold while either line misses or a load is still out
	assign pcOk = (missEven || missOdd || loadPending) ? icachePkg::okHold : icachePkg::okReady;

endmodule

`default_nettype wire

/* hw/ringMissUnit.sv */
//////////////////////////////
// Ring bus node for line loads, at most one per bank in flight
// Slots not free for us are forwarded one cycle later unchanged
// Fill index and tag come from a 16-entry table per rover value
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ringMissUnit (
	input wire clock,
	input wire reset,
	input wire icachePkg::nodeId unitNodeId,
	input wire icachePkg::ringSlot ringIn,
	input wire icachePkg::fetchRequest request,
	input wire missEven,
	input wire missOdd,
	output icachePkg::ringSlot ringOut,
	output icachePkg::bankFill evenFill,
	output icachePkg::bankFill oddFill,
	output logic memWait,
	output logic loadPending
);

	icachePkg::lineIndex seqIndexMem [16];
	icachePkg::lineAddr seqLineMem [16];
	icachePkg::seqTag seqRover;
	icachePkg::ringSlot requestSlot;
	icachePkg::lineIndex issueIndex;
	icachePkg::lineAddr issueLine;
	icachePkg::lineIndex fillIndex;
	icachePkg::lineAddr fillTag;
	logic loadEven;			// Even line load outstanding
	logic loadOdd;
	logic slotIdle;
	logic slotOurs;
	logic slotFree;
	logic okLoad;
	logic respEven;
	logic respOdd;
	logic issueEven;
	logic issueOdd;
	logic issueAny;

	assign slotIdle = ringIn.opm[7:0] == icachePkg::opmIdle;
	assign slotOurs = (ringIn.opm[7:6] == 2'b01) && (ringIn.seq[15:8] == unitNodeId);
	assign slotFree = slotIdle || slotOurs;
	assign okLoad = ringIn.opm[5:4] == 2'b11;
	assign respEven = slotOurs && (ringIn.seq[7:6] == 2'b00);
	assign respOdd = slotOurs && (ringIn.seq[7:6] == 2'b01);

	assign fillIndex = seqIndexMem[ringIn.seq[3:0]];
	assign fillTag = seqLineMem[ringIn.seq[3:0]];

	always_comb
	begin
		evenFill.valid = respEven && okLoad;
		evenFill.index = fillIndex;
		evenFill.tag = fillTag;
		evenFill.data = ringIn.data;
		oddFill.valid = respOdd && okLoad;
		oddFill.index = fillIndex;
		oddFill.tag = fillTag;
		oddFill.data = ringIn.data;
	end

	// Even line goes first
	assign issueEven = missEven && !loadEven;
	assign issueOdd = missOdd && !loadOdd && !issueEven;
	assign issueAny = issueEven || issueOdd;

	always_comb
	begin
		requestSlot.opm = {8'h00, icachePkg::opmIdle};
		requestSlot.seq = '0;
		requestSlot.addr = '0;
		requestSlot.data = '0;
		issueIndex = request.evenIndex;
		issueLine = request.evenLine;
		if (issueEven)
		begin
			requestSlot.opm = {8'h00, icachePkg::opmLoadLine};
			requestSlot.seq = {unitNodeId, 4'b0000, seqRover};
			requestSlot.addr = {request.evenLine, 4'h0};
		end
		else if (issueOdd)
		begin
			requestSlot.opm = {8'h00, icachePkg::opmLoadLine};
			requestSlot.seq = {unitNodeId, 4'b0100, seqRover};	// Bank bits 01
			requestSlot.addr = {request.oddLine, 4'h0};
			issueIndex = request.oddIndex;
			issueLine = request.oddLine;
		end
	end

	assign memWait = missEven || missOdd;
	assign loadPending = loadEven || loadOdd;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOut <= ringIn;
			loadEven <= 1'b0;
			loadOdd <= 1'b0;
			seqRover <= '0;
		end
		else if (slotFree)
		begin
			ringOut <= requestSlot;
			loadEven <= (loadEven && !respEven) || issueEven;
			loadOdd <= (loadOdd && !respOdd) || issueOdd;
			if (issueAny)
				seqRover <= seqRover + 4'd1;
		end
		else
		begin
			ringOut <= ringIn;		// Back pressure, request waits
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset && slotFree && issueAny)
		begin
			seqIndexMem[seqRover] <= issueIndex;
			seqLineMem[seqRover] <= issueLine;
		end
	end

endmodule

`default_nettype wire

/* project.f */
hw/icachePkg.sv
hw/icacheBank.sv
hw/fetchStage.sv
hw/fetchWindow.sv
hw/ringMissUnit.sv
hw/instructionCache.sv
verification/instructionCache_sva.sv
verification/instructionCacheTb.sv

/* verification/icacheInput.txt */
// Columns: payload _ address (48 bits) _ kind; kind 1 = image line, kind 2 = fetch
// Image payload is the 128-bit line; fetch payload digits: miss hit flush wex step
FE000000E00012340000FE000000FE00_000000001000_1
33330000E000222211110000FE000000_000000001010_1
0123456789ABCDEF0011223344556677_000000001020_1
1001C_000000001000_2
0101C_000000001000_2
01004_000000001000_2
01018_000000001004_2
01012_000000001008_2
01014_00000000100A_2
0101C_00000000100E_2
01002_00000000100C_2
10012_000000001010_2
01014_00000000101A_2
01002_00000000101E_2
1011C_000000001000_2
0101C_000000001000_2
10012_000000008000_2
10004_000000001000_2

/* verification/instructionCacheTb.sv */
//////////////////////////////
// Testbench for instructionCache with a ring memory model
// Stimulus and expected steps come from icacheInput.txt
// Ring responses arrive 1 to 6 cycles after a request
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instructionCacheTb;

	localparam icachePkg::nodeId ourNode = 8'h3C;
	localparam int timeoutCycles = 200;

	logic clock;
	logic reset;
	icachePkg::pcAddr pcIn;
	logic pcHold;
	logic wexEnable;
	icachePkg::cacheOpm pcOpm;
	icachePkg::ringSlot ringIn;
	icachePkg::fetchWord pcValue;
	icachePkg::pcOkCode pcOk;
	icachePkg::pcStep pcStep;
	logic memWait;
	icachePkg::ringSlot ringOut;

	logic [179:0] records [64];		// {payload, addr, kind}
	icachePkg::lineData imageMem [icachePkg::lineAddr];
	logic [15:0] pendSeq [$];
	icachePkg::pcAddr pendAddr [$];
	int pendDue [$];
	int cycleCount;
	int reqCount;
	int testCount;
	int failCount;
	logic [31:0] rngState;
	logic [31:0] foreignRand;
	logic injectArm;
	icachePkg::ringSlot injectSlot;

	instructionCache i_dut (
		.clock(clock),
		.reset(reset),
		.pcIn(pcIn),
		.pcHold(pcHold),
		.wexEnable(wexEnable),
		.pcOpm(pcOpm),
		.ringIn(ringIn),
		.unitNodeId(ourNode),
		.pcValue(pcValue),
		.pcOk(pcOk),
		.pcStep(pcStep),
		.memWait(memWait),
		.ringOut(ringOut)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic icachePkg::lineData imageLine(input icachePkg::lineAddr la);
		return imageMem.exists(la) ? imageMem[la] : '0;		// Unknown lines read as zero
	endfunction

	function automatic icachePkg::fetchWord expectedWindow(input icachePkg::pcAddr pc);
		logic [255:0] pair;
		pair = {imageLine(pc[47:4] + 44'd1), imageLine(pc[47:4])};
		return pair[{pc[3:0], 3'b000} +: 96];
	endfunction

	function automatic logic isWideWord(input logic [15:0] h);
		return (h[15:13] == 3'b111) && ((h[12:10] == 3'b111) || (h[12:10] == 3'b101) ||
			(h[12:9] == 4'h7) || (h[12:9] == 4'h5));
	endfunction

	function automatic icachePkg::pcStep referenceStep(input icachePkg::fetchWord w,
		input logic wex);
		if (w[15:13] != 3'b111)
			return 4'd2;
		if (wex && isWideWord(w[15:0]))
			return isWideWord(w[47:32]) ? 4'd12 : 4'd8;
		return 4'd4;
	endfunction

	// Ring memory model, answers loads in order
	always @(posedge clock)
	begin
		if (reset)
		begin
			ringIn <= '0;
			cycleCount = 0;
			pendSeq.delete();
			pendAddr.delete();
			pendDue.delete();
		end
		else
		begin
			cycleCount = cycleCount + 1;
			if (ringOut.opm[7:0] == icachePkg::opmLoadLine && ringOut.seq[15:8] == ourNode)
			begin
				pendSeq.push_back(ringOut.seq);
				pendAddr.push_back(ringOut.addr);
				pendDue.push_back(cycleCount + 1 + int'(nextRandom() % 6));
				reqCount = reqCount + 1;
			end
			if (injectArm)
			begin
				ringIn <= injectSlot;
				injectArm = 1'b0;
			end
			else if (pendDue.size() > 0 && cycleCount >= pendDue[0])
			begin
				ringIn.opm <= 16'h0070;		// Response, OK load
				ringIn.seq <= pendSeq.pop_front();
				ringIn.addr <= pendAddr[0];
				ringIn.data <= imageLine(pendAddr[0][47:4]);
				void'(pendAddr.pop_front());
				void'(pendDue.pop_front());
			end
			else if (nextRandom() % 8 == 0)
			begin
				foreignRand = nextRandom();
				ringIn.opm <= 16'h0055;		// Traffic for another node
				ringIn.seq <= {8'h11, foreignRand[7:0]};
				ringIn.addr <= {16'h0, nextRandom()};
				ringIn.data <= {4{nextRandom()}};
			end
			else
				ringIn <= '0;
		end
	end

	task automatic reportMismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		failCount++;
	endtask

	task automatic waitForReady();
		int waitCycles;
		waitCycles = 0;
		while (pcOk != icachePkg::okReady && waitCycles < timeoutCycles)
		begin
			@(posedge clock);
			pcHold <= 1'b1;
			@(negedge clock);
			waitCycles++;
		end
		if (pcOk != icachePkg::okReady)
		begin
			$display("Timeout: the cache never returned okReady for pc %h", pcIn);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic runFetch(input logic [179:0] rec);
		icachePkg::pcAddr pc;
		icachePkg::pcStep fileStep;
		icachePkg::fetchWord window;
		logic wex;
		logic doFlush;
		logic expectHit;
		logic expectMiss;
		int startReqs;
		int startFails;
		pc = rec[51:4];
		fileStep = rec[55:52];
		wex = rec[56];
		doFlush = rec[60];
		expectHit = rec[64];
		expectMiss = rec[68];
		startFails = failCount;
		if (doFlush)
		begin
			@(posedge clock);
			pcOpm <= icachePkg::opmFlushIcache;
			@(posedge clock);
			pcOpm <= '0;
			repeat (4) @(posedge clock);
			@(negedge clock);
			waitForReady();		// Let the refetch of the old PC settle
		end
		startReqs = reqCount;
		@(posedge clock);
		pcIn <= pc;
		pcHold <= 1'b0;
		wexEnable <= wex;
		@(posedge clock);
		@(negedge clock);
		if (expectHit && pcOk != icachePkg::okReady)
			reportMismatch($sformatf("pc %h not ready one cycle after fetch", pc));
		if (expectMiss && pcOk != icachePkg::okHold)
			reportMismatch($sformatf("pc %h expected okHold on a miss", pc));
		if ((expectHit || expectMiss) && memWait !== expectMiss)
			reportMismatch($sformatf("pc %h memWait %b, expected %b", pc, memWait, expectMiss));
		waitForReady();
		window = expectedWindow(pc);
		if (pcValue !== window)
			reportMismatch($sformatf("pc %h window %h, expected %h", pc, pcValue, window));
		if (pcStep !== fileStep)
			reportMismatch($sformatf("pc %h step %0d, expected %0d", pc, pcStep, fileStep));
		if (pcStep !== referenceStep(window, wex))
			reportMismatch($sformatf("pc %h step %0d, decode rule gives %0d", pc, pcStep,
				referenceStep(window, wex)));
		if (expectMiss && reqCount == startReqs)
			reportMismatch($sformatf("pc %h missed without a load request", pc));
		testCount++;
		$display("%s fetch pc=%h wex=%0d flush=%0d step=%0d",
			(failCount == startFails) ? "pass" : "fail", pc, wex, doFlush, pcStep);
	endtask

	task automatic checkForwarding();
		int waitCycles;
		waitCycles = 0;
		@(negedge clock);
		while (pendDue.size() != 0 && waitCycles < timeoutCycles)
		begin
			@(negedge clock);
			waitCycles++;
		end
		if (pendDue.size() != 0)
		begin
			$display("Timeout: ring loads still outstanding before forwarding test");
			$display("TEST FAILED");
			$finish;
		end
		injectSlot = {16'h0055, 16'h22A5, 48'h0000DEAD0000, {4{32'hC0FFEE11}}};
		injectArm = 1'b1;
		@(posedge clock);		// Model drives the slot
		@(posedge clock);		// DUT forwards it
		@(negedge clock);
		testCount++;
		if (ringOut !== injectSlot)
		begin
			reportMismatch("foreign slot not forwarded unchanged");
			$display("fail forwarding");
		end
		else
			$display("pass forwarding");
	endtask

	initial
	begin
		reset = 1'b1;
		pcIn = '0;
		pcHold = 1'b0;
		wexEnable = 1'b0;
		pcOpm = '0;
		ringIn = '0;
		injectArm = 1'b0;
		injectSlot = '0;
		rngState = 32'd57059;
		foreignRand = '0;
		reqCount = 0;
		testCount = 0;
		failCount = 0;
		foreach (records[i])
			records[i] = '0;
		$readmemh("verification/icacheInput.txt", records);
		foreach (records[i])
			if (records[i][3:0] == 4'd1)
				imageMem[records[i][51:8]] = records[i][179:52];
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		testCount++;
		if (memWait !== 1'b0 || ringOut.opm[7:0] !== icachePkg::opmIdle)
		begin
			reportMismatch("memWait or ring opm wrong after reset");
			$display("fail reset state");
		end
		else
			$display("pass reset state");
		foreach (records[i])
			if (records[i][3:0] == 4'd2)
				runFetch(records[i]);
		checkForwarding();
		$display("Tests run %0d, failures %0d", testCount, failCount);
		if (failCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/instructionCache_sva.sv */
//////////////////////////////
// Ring and reset assertions, bound into instructionCache
// A foreign slot is neither idle nor a response to this node
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instructionCacheChecks (
	input wire clock,
	input wire reset,
	input wire memWait,
	input wire icachePkg::nodeId unitNodeId,
	input wire icachePkg::ringSlot ringIn,
	input wire icachePkg::ringSlot ringOut
);

	logic foreignSlot;

	assign foreignSlot = (ringIn.opm[7:0] != icachePkg::opmIdle) &&
		!((ringIn.opm[7:6] == 2'b01) && (ringIn.seq[15:8] == unitNodeId));

	memWaitAfterReset: assert property (@(posedge clock) $fell(reset) |-> !memWait)
		else $error("memWait high in the cycle after reset");

	ringOpmKnown: assert property (@(posedge clock) !reset |-> !$isunknown(ringOut.opm))
		else $error("ring output opm unknown");

	foreignForwarded: assert property (@(posedge clock) disable iff (reset)
		foreignSlot |=> ringOut == $past(ringIn))
		else $error("foreign slot changed on forwarding");

endmodule

bind instructionCache instructionCacheChecks i_checks (
	.clock(clock),
	.reset(reset),
	.memWait(memWait),
	.unitNodeId(unitNodeId),
	.ringIn(ringIn),
	.ringOut(ringOut)
);

`default_nettype wire
